// File: all.f
verilog/cache_ctrl_pkg.sv
verilog/cache_bus_pkg.sv
verilog/cache_front_end.sv
verilog/cache_memory.sv
verilog/cache_back_end.sv
verilog/cache_control.sv
verilog/cache_top.sv
sim/main_memory_model.sv
sim/cache_asserts.sv
sim/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module cache_tb -Mdir obj_dir -f all.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/Vcache_tb
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi

exit 0

// File: sim/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

   localparam int ADDR_W   = cache_bus_pkg::ADDR_W;
   localparam int DATA_W   = cache_bus_pkg::DATA_W;
   localparam int INDEX_W  = cache_bus_pkg::INDEX_W;
   localparam int TAG_W    = ADDR_W - 1 - INDEX_W;
   localparam int STRB_W   = DATA_W / 8;
   localparam int MAX_LAT  = 7;
   localparam int NUM_RAND = 200;
   // Directed and random requests, each at most one memory round trip plus overhead
   localparam int NUM_REQ  = 60 + NUM_RAND;
   localparam int TIMEOUT  = NUM_REQ * (MAX_LAT + 8) + 200;

   logic                    clk;
   logic                    rst_n;
   logic                    avalid;
   logic [ADDR_W-1:0]       addr;
   logic [DATA_W-1:0]       wdata;
   logic [STRB_W-1:0]       wstrb;
   logic [DATA_W-1:0]       rdata;
   logic                    rvalid;
   logic                    ready;
   logic                    mem_req;
   cache_bus_pkg::mem_req_t mem_txn;
   logic                    mem_ack;
   logic [DATA_W-1:0]       mem_rdata;

   // Shadow state of the reference model
   logic [DATA_W-1:0]       shadow_mem [int unsigned];
   logic [TAG_W-1:0]        shadow_tag [2**INDEX_W];
   logic [2**INDEX_W-1:0]   shadow_valid;
   logic [31:0]             shadow_hits;
   logic [31:0]             shadow_misses;
   logic [DATA_W-1:0]       exp_data_q [$];
   string                   exp_name_q [$];
   int                      cycles = 0;

   cache_top #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W),
      .INDEX_W(INDEX_W)
   ) UUT (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .avalid_i   (avalid),
      .addr_i     (addr),
      .wdata_i    (wdata),
      .wstrb_i    (wstrb),
      .rdata_o    (rdata),
      .rvalid_o   (rvalid),
      .ready_o    (ready),
      .mem_req_o  (mem_req),
      .mem_o      (mem_txn),
      .mem_ack_i  (mem_ack),
      .mem_rdata_i(mem_rdata)
   );

   main_memory_model #(
      .DATA_W (DATA_W),
      .MAX_LAT(MAX_LAT)
   ) mem_model (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .mem_req_i  (mem_req),
      .mem_i      (mem_txn),
      .mem_ack_o  (mem_ack),
      .mem_rdata_o(mem_rdata)
   );

   always #10 clk = ~clk;

   function automatic logic [DATA_W-1:0] initial_word(logic [ADDR_W-2:0] a);
      return ({1'b0, a} * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
   endfunction

   function automatic logic [DATA_W-1:0] shadow_word(logic [ADDR_W-2:0] a);
      int unsigned key;
      key = {1'b0, a};
      if (shadow_mem.exists(key)) begin
         return shadow_mem[key];
      end else begin
         return initial_word(a);
      end
   endfunction

   function automatic logic [ADDR_W-1:0] reg_addr(logic [cache_ctrl_pkg::REG_IDX_W-1:0] idx);
      return {1'b1, {(ADDR_W - 1 - cache_ctrl_pkg::REG_IDX_W){1'b0}}, idx};
   endfunction

   // Expected read data, updates shadow memory, tags and counters
   function automatic logic [DATA_W-1:0] predict(logic [ADDR_W-1:0] a, logic [DATA_W-1:0] wd,
                                                 logic [STRB_W-1:0] ws);
      cache_bus_pkg::cache_addr_t ca;
      logic [DATA_W-1:0]          word;
      logic [INDEX_W-1:0]         idx;
      ca = a;
      idx = ca.data.index;
      predict = '0;
      if (ca.ctrl.sel) begin
         if (ws != '0) begin
            if (ca.ctrl.reg_idx == cache_ctrl_pkg::REG_CLR_CNT) begin
               shadow_hits   = '0;
               shadow_misses = '0;
            end else if (ca.ctrl.reg_idx == cache_ctrl_pkg::REG_INVALIDATE) begin
               shadow_valid = '0;
            end
         end else if (ca.ctrl.reg_idx == cache_ctrl_pkg::REG_HIT_CNT) begin
            predict = shadow_hits;
         end else if (ca.ctrl.reg_idx == cache_ctrl_pkg::REG_MISS_CNT) begin
            predict = shadow_misses;
         end
      end else begin
         word = shadow_word(a[ADDR_W-2:0]);
         if (ws != '0) begin
            for (int b = 0; b < STRB_W; b++) begin
               if (ws[b]) begin
                  word[8*b +: 8] = wd[8*b +: 8];
               end
            end
            shadow_mem[{1'b0, a[ADDR_W-2:0]}] = word;
         end else begin
            if (shadow_valid[idx] && shadow_tag[idx] == ca.data.tag) begin
               shadow_hits = shadow_hits + 1;
            end else begin
               // Read miss allocates the line
               shadow_misses     = shadow_misses + 1;
               shadow_valid[idx] = 1'b1;
               shadow_tag[idx]   = ca.data.tag;
            end
            predict = word;
         end
      end
   endfunction

   task automatic check(input string name, input logic [DATA_W-1:0] expected,
                        input logic [DATA_W-1:0] actual);
      if (actual !== expected) begin
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         $display("TESTS FAILED");
         $fatal(1, "read data mismatch");
      end
   endtask

   // Called 2 ns after a rising edge, returns 2 ns after the accepting edge
   task automatic issue(input string name, input logic [ADDR_W-1:0] a,
                        input logic [DATA_W-1:0] wd, input logic [STRB_W-1:0] ws);
      logic [DATA_W-1:0] expected;
      expected = predict(a, wd, ws);
      if (ws == '0) begin
         exp_data_q.push_back(expected);
         exp_name_q.push_back(name);
      end
      avalid = 1'b1;
      addr   = a;
      wdata  = wd;
      wstrb  = ws;
      @(negedge clk);
      while (!ready) begin
         @(negedge clk);
      end
      @(posedge clk);
      #2;
      avalid = 1'b0;
   endtask

   task automatic load(input string name, input logic [ADDR_W-1:0] a);
      issue(name, a, '0, '0);
   endtask

   task automatic store(input string name, input logic [ADDR_W-1:0] a,
                        input logic [DATA_W-1:0] wd, input logic [STRB_W-1:0] ws);
      issue(name, a, wd, ws);
   endtask

   // Wait for the last responses, bounded by one memory round trip
   task automatic drain();
      int waited;
      waited = 0;
      @(negedge clk);
      while ((exp_data_q.size() != 0 || !ready) && waited < MAX_LAT + 10) begin
         waited++;
         @(negedge clk);
      end
   endtask

   always @(negedge clk) begin
      if (rst_n && rvalid) begin
         if (exp_data_q.size() == 0) begin
            $display("Read response %h arrived with no read outstanding", rdata);
            $display("TESTS FAILED");
            $fatal(1, "unexpected read response");
         end else begin
            check(exp_name_q.pop_front(), exp_data_q.pop_front(), rdata);
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("Timeout after %0d cycles, the cache stopped answering", cycles);
         $display("TESTS FAILED");
         $fatal(1, "timeout");
      end
   end

   initial begin
      logic [ADDR_W-1:0] a;
      logic [STRB_W-1:0] ws;
      void'($urandom(32'hde52_9208));
      clk           = 1'b0;
      rst_n         = 1'b0;
      avalid        = 1'b0;
      addr          = '0;
      wdata         = '0;
      wstrb         = '0;
      shadow_valid  = '0;
      shadow_hits   = '0;
      shadow_misses = '0;
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      @(posedge clk);
      #2;

      load("cold read miss", 32'h0000_0010);
      load("repeat read hit", 32'h0000_0010);
      load("hit count after first hit", reg_addr(cache_ctrl_pkg::REG_HIT_CNT));
      load("miss count after cold miss", reg_addr(cache_ctrl_pkg::REG_MISS_CNT));

      // Write miss does not allocate, so the read fetches from memory
      store("full word write", 32'h0000_0124, 32'hcafe_f00d, 4'hf);
      load("read after write", 32'h0000_0124);
      store("full word write on hit", 32'h0000_0124, 32'h0bad_beef, 4'hf);
      load("read after write hit", 32'h0000_0124);

      store("partial write hit", 32'h0000_0010, 32'h1122_3344, 4'b0101);
      load("merged bytes on hit", 32'h0000_0010);
      store("partial write miss", 32'h0000_02a0, 32'h5566_7788, 4'b1000);
      load("merged bytes on miss", 32'h0000_02a0);
      store("partial write hit middle", 32'h0000_02a0, 32'h99aa_bbcc, 4'b0110);
      load("merged bytes after two writes", 32'h0000_02a0);

      // Index 5 shared by tag 0 and tag 1
      for (int i = 0; i < 4; i++) begin
         load("conflict read tag 0", 32'h0000_0005);
         load("conflict read tag 1", 32'h0000_0045);
      end
      load("miss count after conflicts", reg_addr(cache_ctrl_pkg::REG_MISS_CNT));
      load("hit count after conflicts", reg_addr(cache_ctrl_pkg::REG_HIT_CNT));

      store("clear counters", reg_addr(cache_ctrl_pkg::REG_CLR_CNT), '0, 4'hf);
      load("hit count cleared", reg_addr(cache_ctrl_pkg::REG_HIT_CNT));
      load("miss count cleared", reg_addr(cache_ctrl_pkg::REG_MISS_CNT));
      load("clear register reads zero", reg_addr(cache_ctrl_pkg::REG_CLR_CNT));
      load("unused register reads zero", reg_addr(3'd6));
      load("cached read before invalidate", 32'h0000_0124);
      store("invalidate all", reg_addr(cache_ctrl_pkg::REG_INVALIDATE), '0, 4'hf);
      load("read after invalidate", 32'h0000_0124);
      load("partial write reached memory", 32'h0000_0010);
      load("hit count after invalidate", reg_addr(cache_ctrl_pkg::REG_HIT_CNT));
      load("miss count after invalidate", reg_addr(cache_ctrl_pkg::REG_MISS_CNT));

      // Random mix over four tags and eight indices
      for (int n = 0; n < NUM_RAND; n++) begin
         a = '0;
         a[INDEX_W +: 2] = 2'($urandom);
         a[2:0] = 3'($urandom);
         if ($urandom % 2 == 0) begin
            load("random read", a);
         end else begin
            ws = STRB_W'($urandom);
            if (ws == '0) begin
               ws = '1;
            end
            store("random write", a, $urandom, ws);
         end
         if (n % 25 == 24) begin
            load("random miss count", reg_addr(cache_ctrl_pkg::REG_MISS_CNT));
            load("random hit count", reg_addr(cache_ctrl_pkg::REG_HIT_CNT));
         end
      end

      drain();
      if (exp_data_q.size() != 0) begin
         $display("%0d reads never returned a response", exp_data_q.size());
         $display("TESTS FAILED");
         $fatal(1, "missing read responses");
      end else if (!ready) begin
         $display("The last request was never acknowledged");
         $display("TESTS FAILED");
         $fatal(1, "cache still busy");
      end else begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: sim/cache_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cache_asserts #(
   parameter int PAYLOAD_W = 1
) (
   input wire                 clk_i,
   input wire                 rst_n_i,
   input wire                 req_i,
   input wire                 ack_i,
   input wire [PAYLOAD_W-1:0] payload_i
);

   // Outstanding request keeps its payload until acknowledged
   payload_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_i && !ack_i |=> $stable(payload_i))
      else $error("request payload changed while waiting");

   ack_with_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ack_i |-> req_i)
      else $error("acknowledge without an outstanding request");

endmodule

bind cache_front_end cache_asserts #(
   .PAYLOAD_W($bits(cache_bus_pkg::bus_req_t))
) front_end_checks (
   .clk_i    (clk_i),
   .rst_n_i  (rst_n_i),
   .req_i    (busy_q),
   .ack_i    (ack),
   .payload_i(req_q)
);

bind cache_back_end cache_asserts #(
   .PAYLOAD_W($bits(cache_bus_pkg::mem_req_t))
) back_end_checks (
   .clk_i    (clk_i),
   .rst_n_i  (rst_n_i),
   .req_i    (mem_req_o),
   .ack_i    (mem_ack_i),
   .payload_i(mem_o)
);

`default_nettype wire

// File: sim/main_memory_model.sv
`timescale 1ns/1ps
`default_nettype none

module main_memory_model #(
   parameter int DATA_W  = cache_bus_pkg::DATA_W,
   parameter int MAX_LAT = 7
) (
   input  wire                          clk_i,
   input  wire                          rst_n_i,
   input  wire                          mem_req_i,
   input  wire cache_bus_pkg::mem_req_t mem_i,
   output logic                         mem_ack_o,
   output logic [DATA_W-1:0]            mem_rdata_o
);

   // Only written words are stored, the rest read as a fill pattern
   logic [DATA_W-1:0] words [int unsigned];
   logic              busy_q;
   int unsigned       wait_q;

   function automatic logic [DATA_W-1:0] initial_word(logic [cache_bus_pkg::ADDR_W-2:0] a);
      return ({1'b0, a} * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
   endfunction

   always @(posedge clk_i or negedge rst_n_i) begin : respond
      logic [DATA_W-1:0] word;
      int unsigned       key;
      if (!rst_n_i) begin
         busy_q      <= 1'b0;
         wait_q      <= 0;
         mem_ack_o   <= 1'b0;
         mem_rdata_o <= '0;
      end else begin
         mem_ack_o <= 1'b0;
         if (busy_q) begin
            if (wait_q == 0) begin
               key  = {1'b0, mem_i.addr};
               word = words.exists(key) ? words[key] : initial_word(mem_i.addr);
               if (mem_i.we) begin
                  for (int b = 0; b < DATA_W / 8; b++) begin
                     if (mem_i.wstrb[b]) begin
                        word[8*b +: 8] = mem_i.wdata[8*b +: 8];
                     end
                  end
                  words[key] = word;
               end
               mem_rdata_o <= word;
               mem_ack_o   <= 1'b1;
               busy_q      <= 1'b0;
            end else begin
               wait_q <= wait_q - 1;
            end
         end else if (mem_req_i && !mem_ack_o) begin
            // New transaction, pick its latency
            busy_q <= 1'b1;
            wait_q <= $urandom % (MAX_LAT + 1);
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
   parameter int ADDR_W  = cache_bus_pkg::ADDR_W,
   parameter int DATA_W  = cache_bus_pkg::DATA_W,
   parameter int INDEX_W = cache_bus_pkg::INDEX_W
) (
   input  wire                     clk_i,
   input  wire                     rst_n_i,

   // Processor bus
   input  wire                     avalid_i,
   input  wire [ADDR_W-1:0]        addr_i,
   input  wire [DATA_W-1:0]        wdata_i,
   input  wire [DATA_W/8-1:0]      wstrb_i,
   output logic [DATA_W-1:0]       rdata_o,
   output logic                    rvalid_o,
   output logic                    ready_o,

   // Backing memory
   output logic                    mem_req_o,
   output cache_bus_pkg::mem_req_t mem_o,
   input  wire                     mem_ack_i,
   input  wire [DATA_W-1:0]        mem_rdata_i
);

   cache_bus_pkg::bus_req_t bus_req;
   cache_bus_pkg::mem_req_t mem_req;
   logic                    data_req;
   logic                    data_ack;
   logic [DATA_W-1:0]       data_rdata;
   logic                    ctrl_req;
   logic                    ctrl_ack;
   logic [DATA_W-1:0]       ctrl_rdata;
   logic                    mem_start;
   logic                    mem_done;
   logic [DATA_W-1:0]       mem_rdata;
   logic                    hit;
   logic                    miss;
   logic                    invalidate;

   cache_front_end front_end (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .avalid_i    (avalid_i),
      .addr_i      (addr_i),
      .wdata_i     (wdata_i),
      .wstrb_i     (wstrb_i),
      .rdata_o     (rdata_o),
      .rvalid_o    (rvalid_o),
      .ready_o     (ready_o),
      .data_req_o  (data_req),
      .req_o       (bus_req),
      .data_ack_i  (data_ack),
      .data_rdata_i(data_rdata),
      .ctrl_req_o  (ctrl_req),
      .ctrl_ack_i  (ctrl_ack),
      .ctrl_rdata_i(ctrl_rdata)
   );

   cache_memory #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W),
      .INDEX_W(INDEX_W)
   ) memory (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .data_req_i  (data_req),
      .req_i       (bus_req),
      .ack_o       (data_ack),
      .rdata_o     (data_rdata),
      .mem_start_o (mem_start),
      .mem_req_o   (mem_req),
      .mem_done_i  (mem_done),
      .mem_rdata_i (mem_rdata),
      .hit_o       (hit),
      .miss_o      (miss),
      .invalidate_i(invalidate)
   );

   cache_back_end #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) back_end (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .start_i    (mem_start),
      .req_i      (mem_req),
      .done_o     (mem_done),
      .rdata_o    (mem_rdata),
      .mem_req_o  (mem_req_o),
      .mem_o      (mem_o),
      .mem_ack_i  (mem_ack_i),
      .mem_rdata_i(mem_rdata_i)
   );

   cache_control #(
      .DATA_W(DATA_W)
   ) control (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .ctrl_req_i  (ctrl_req),
      .req_i       (bus_req),
      .ack_o       (ctrl_ack),
      .rdata_o     (ctrl_rdata),
      .hit_i       (hit),
      .miss_i      (miss),
      .invalidate_o(invalidate)
   );

endmodule

`default_nettype wire

// File: verilog/cache_control.sv
`timescale 1ns/1ps
`default_nettype none

module cache_control #(
   parameter int DATA_W = cache_bus_pkg::DATA_W
) (
   input  wire                  clk_i,
   input  wire                  rst_n_i,

   input  wire                  ctrl_req_i,
   input  wire cache_bus_pkg::bus_req_t req_i,
   output logic                 ack_o,
   output logic [DATA_W-1:0]    rdata_o,

   input  wire                  hit_i,
   input  wire                  miss_i,
   output logic                 invalidate_o
);

   logic [cache_ctrl_pkg::CNT_W-1:0]     hit_cnt_q;
   logic [cache_ctrl_pkg::CNT_W-1:0]     miss_cnt_q;
   logic [cache_ctrl_pkg::REG_IDX_W-1:0] reg_idx;
   logic                                 wr;
   logic                                 clr;

   assign reg_idx = req_i.addr.ctrl.reg_idx;
   assign wr      = ctrl_req_i && req_i.we;

   // Writes to these two indices are commands only
   assign clr          = wr && (reg_idx == cache_ctrl_pkg::REG_CLR_CNT);
   assign invalidate_o = wr && (reg_idx == cache_ctrl_pkg::REG_INVALIDATE);

   // Registers answer in the cycle after acceptance
   assign ack_o = ctrl_req_i;

   always_comb begin
      rdata_o = '0;
      if (!req_i.we) begin
         case (reg_idx)
            cache_ctrl_pkg::REG_HIT_CNT:  rdata_o = DATA_W'(hit_cnt_q);
            cache_ctrl_pkg::REG_MISS_CNT: rdata_o = DATA_W'(miss_cnt_q);
            default:                      rdata_o = '0;
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hit_cnt_q  <= '0;
         miss_cnt_q <= '0;
      end else if (clr) begin
         hit_cnt_q  <= '0;
         miss_cnt_q <= '0;
      end else begin
         if (hit_i) begin
            hit_cnt_q <= hit_cnt_q + 1'b1;
         end
         if (miss_i) begin
            miss_cnt_q <= miss_cnt_q + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/cache_back_end.sv
`timescale 1ns/1ps
`default_nettype none

module cache_back_end #(
   parameter int ADDR_W = cache_bus_pkg::ADDR_W,
   parameter int DATA_W = cache_bus_pkg::DATA_W
) (
   input  wire                     clk_i,
   input  wire                     rst_n_i,

   input  wire                     start_i,
   input  wire cache_bus_pkg::mem_req_t req_i,
   output logic                    done_o,
   output logic [DATA_W-1:0]       rdata_o,

   // Backing memory
   output logic                    mem_req_o,
   output cache_bus_pkg::mem_req_t mem_o,
   input  wire                     mem_ack_i,
   input  wire [DATA_W-1:0]        mem_rdata_i
);

   logic [ADDR_W-2:0]   addr_q;
   logic [DATA_W-1:0]   wdata_q;
   logic [DATA_W/8-1:0] wstrb_q;
   logic                we_q;

   assign mem_o.addr  = addr_q;
   assign mem_o.wdata = wdata_q;
   assign mem_o.wstrb = wstrb_q;
   assign mem_o.we    = we_q;

   // Request level held until the memory answers
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         mem_req_o <= 1'b0;
         done_o    <= 1'b0;
      end else begin
         done_o <= mem_req_o && mem_ack_i;
         if (start_i) begin
            mem_req_o <= 1'b1;
         end else if (mem_ack_i) begin
            mem_req_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i) begin
         addr_q  <= req_i.addr;
         wdata_q <= req_i.wdata;
         wstrb_q <= req_i.wstrb;
         we_q    <= req_i.we;
      end
      if (mem_req_o && mem_ack_i) begin
         rdata_o <= mem_rdata_i;
      end
   end

endmodule

`default_nettype wire

// File: verilog/cache_memory.sv
`timescale 1ns/1ps
`default_nettype none

module cache_memory #(
   parameter int ADDR_W  = cache_bus_pkg::ADDR_W,
   parameter int DATA_W  = cache_bus_pkg::DATA_W,
   parameter int INDEX_W = cache_bus_pkg::INDEX_W
) (
   input  wire                      clk_i,
   input  wire                      rst_n_i,

   input  wire                      data_req_i,
   input  wire cache_bus_pkg::bus_req_t req_i,
   output logic                     ack_o,
   output logic [DATA_W-1:0]        rdata_o,

   // Toward the back end
   output logic                     mem_start_o,
   output cache_bus_pkg::mem_req_t  mem_req_o,
   input  wire                      mem_done_i,
   input  wire [DATA_W-1:0]         mem_rdata_i,

   // Statistics and maintenance
   output logic                     hit_o,
   output logic                     miss_o,
   input  wire                      invalidate_i
);

   localparam int TAG_W = ADDR_W - 1 - INDEX_W;
   localparam int LINES = 2 ** INDEX_W;

   typedef enum logic {
      S_LOOKUP,
      S_WAIT
   } state_t;

   state_t             state_q;
   logic [TAG_W-1:0]   tag_mem  [LINES];
   logic [DATA_W-1:0]  data_mem [LINES];
   logic [LINES-1:0]   valid_q;
   logic [INDEX_W-1:0] idx;
   logic [TAG_W-1:0]   tag;
   logic               hit;
   logic               lookup;
   logic               fill;

   assign idx    = req_i.addr.data.index;
   assign tag    = req_i.addr.data.tag;
   assign hit    = valid_q[idx] && (tag_mem[idx] == tag);
   assign lookup = (state_q == S_LOOKUP) && data_req_i;

   // Fill word arrives with the back-end done pulse
   assign fill = (state_q == S_WAIT) && mem_done_i && !req_i.we;

   assign hit_o  = lookup && !req_i.we && hit;
   assign miss_o = lookup && !req_i.we && !hit;

   // Every write goes through, reads only on a miss
   assign mem_start_o     = lookup && (req_i.we || !hit);
   assign mem_req_o.addr  = {tag, idx};
   assign mem_req_o.wdata = req_i.wdata;
   assign mem_req_o.wstrb = req_i.wstrb;
   assign mem_req_o.we    = req_i.we;

   assign ack_o   = hit_o || ((state_q == S_WAIT) && mem_done_i);
   assign rdata_o = (state_q == S_WAIT) ? mem_rdata_i : data_mem[idx];

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= S_LOOKUP;
      end else if (mem_start_o) begin
         state_q <= S_WAIT;
      end else if (mem_done_i) begin
         state_q <= S_LOOKUP;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= '0;
      end else if (invalidate_i) begin
         valid_q <= '0;
      end else if (fill) begin
         valid_q[idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill) begin
         tag_mem[idx]  <= tag;
         data_mem[idx] <= mem_rdata_i;
      end else if (lookup && req_i.we && hit) begin
         // Write hit merges the strobed bytes
         for (int b = 0; b < DATA_W / 8; b++) begin
            if (req_i.wstrb[b]) begin
               data_mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/cache_front_end.sv
`timescale 1ns/1ps
`default_nettype none

module cache_front_end (
   input  wire                                      clk_i,
   input  wire                                      rst_n_i,

   // Processor bus
   input  wire                                      avalid_i,
   input  wire cache_bus_pkg::cache_addr_t          addr_i,
   input  wire [cache_bus_pkg::DATA_W-1:0]          wdata_i,
   input  wire [cache_bus_pkg::STRB_W-1:0]          wstrb_i,
   output logic [cache_bus_pkg::DATA_W-1:0]         rdata_o,
   output logic                                     rvalid_o,
   output logic                                     ready_o,

   // Registered request toward the responders
   output logic                                     data_req_o,
   output cache_bus_pkg::bus_req_t                  req_o,
   input  wire                                      data_ack_i,
   input  wire [cache_bus_pkg::DATA_W-1:0]          data_rdata_i,

   output logic                                     ctrl_req_o,
   input  wire                                      ctrl_ack_i,
   input  wire [cache_bus_pkg::DATA_W-1:0]          ctrl_rdata_i
);

   logic                    busy_q;
   cache_bus_pkg::bus_req_t req_q;
   logic                    ack;
   logic                    accept;

   assign ack    = data_ack_i || ctrl_ack_i;
   assign accept = avalid_i && ready_o;

   // Free again in the cycle the outstanding request is acknowledged
   assign ready_o = !busy_q || ack;

   // Top address bit picks cache or control registers
   assign data_req_o = busy_q && !req_q.addr.data.sel;
   assign ctrl_req_o = busy_q && req_q.addr.ctrl.sel;
   assign req_o      = req_q;

   assign rdata_o  = ctrl_ack_i ? ctrl_rdata_i : data_rdata_i;
   assign rvalid_o = ack && !req_q.we;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q <= 1'b0;
      end else if (accept) begin
         busy_q <= 1'b1;
      end else if (ack) begin
         busy_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_q.addr  <= addr_i;
         req_q.wdata <= wdata_i;
         req_q.wstrb <= wstrb_i;
         // Any strobe set marks a write
         req_q.we    <= |wstrb_i;
      end
   end

endmodule

`default_nettype wire

// File: verilog/cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

   // Geometry defaults
   parameter int ADDR_W  = 32;
   parameter int DATA_W  = 32;
   parameter int INDEX_W = 6;
   parameter int TAG_W   = ADDR_W - 1 - INDEX_W;
   parameter int STRB_W  = DATA_W / 8;

   // Address seen as cached data
   typedef struct packed {
      logic               sel;
      logic [TAG_W-1:0]   tag;
      logic [INDEX_W-1:0] index;
   } data_view_t;

   // Address seen as a control register
   typedef struct packed {
      logic                                        sel;
      logic [ADDR_W-2-cache_ctrl_pkg::REG_IDX_W:0] rsvd;
      logic [cache_ctrl_pkg::REG_IDX_W-1:0]        reg_idx;
   } ctrl_view_t;

   typedef union packed {
      data_view_t data;
      ctrl_view_t ctrl;
   } cache_addr_t;

   typedef struct packed {
      cache_addr_t       addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
      logic              we;
   } bus_req_t;

   // One backing memory transaction, select bit dropped
   typedef struct packed {
      logic [ADDR_W-2:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
      logic              we;
   } mem_req_t;

endpackage

`default_nettype wire

// File: verilog/cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

   // Width of the control register index
   parameter int REG_IDX_W = 3;

   // Register map
   parameter logic [REG_IDX_W-1:0] REG_HIT_CNT    = 3'd0;
   parameter logic [REG_IDX_W-1:0] REG_MISS_CNT   = 3'd1;

   // Write-only commands
   parameter logic [REG_IDX_W-1:0] REG_CLR_CNT    = 3'd2;
   parameter logic [REG_IDX_W-1:0] REG_INVALIDATE = 3'd3;

   // Hit and miss counter width
   parameter int CNT_W = 32;

endpackage

`default_nettype wire
